// ==== bench/cacheInput.txt ====
# name  mode  address  expected_data  refill_count
# mode 0 starts a test, 1 runs back to back with the test above, 2 resets first
cold_miss        0 00001008 ffffeff700001008 1
same_line_word0  0 00001000 ffffefff00001000 0
same_line_word3  0 0000101c ffffefe700001018 0
b2b_first        0 00001010 ffffefef00001010 0
b2b_second       1 00001000 ffffefff00001000 0
b2b_third        1 00001018 ffffefe700001018 0
other_set_miss   0 80000a68 7ffff59780000a68 1
other_set_hit    0 80000a70 7ffff58f80000a70 0
tag_b_miss       0 00002008 ffffdff700002008 1
tag_a_resident   0 00001008 ffffeff700001008 0
tag_b_resident   0 00002010 ffffdfef00002010 0
tag_c_evicts_a   0 00003000 ffffcfff00003000 1
tag_b_still_hits 0 00002018 ffffdfe700002018 0
tag_a_refills    0 00001008 ffffeff700001008 1
after_reset_miss 2 00002018 ffffdfe700002018 1

// ==== bench/cacheTb.sv ====
module cacheTb;
  timeunit 1ns;
  timeprecision 100ps;

  import cachePkg::*;

  localparam int MaxWait = 100;
  localparam int MaxRecs = 32;

  logic clk;
  logic rst_n;
  logic valid;
  addrT addr;
  logic addrOk;
  logic dataOk;
  dataT rdData;
  logic memRdReq;
  addrT memAddr;
  logic memRdValid;
  logic memRdLast;
  dataT memRdData;

  // records from the input file
  string recName [MaxRecs];
  int    recMode [MaxRecs];
  addrT  recAddr [MaxRecs];
  dataT  recData [MaxRecs];
  int    recFill [MaxRecs];
  int    recCnt;

  int acceptCyc [MaxRecs];
  int reqMark [MaxRecs];
  bit testBad [MaxRecs];
  int cycle;
  int reqCnt;
  int passCnt;
  int failCnt;
  bit aborted;

  cacheTop uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid),
    .addr_i       (addr),
    .addrOk_o     (addrOk),
    .dataOk_o     (dataOk),
    .rdData_o     (rdData),
    .memRdReq_o   (memRdReq),
    .memAddr_o    (memAddr),
    .memRdValid_i (memRdValid),
    .memRdLast_i  (memRdLast),
    .memRdData_i  (memRdData)
  );

  memModel uMem (
    .clk       (clk),
    .rdReq_i   (memRdReq),
    .addr_i    (memAddr),
    .rdValid_o (memRdValid),
    .rdLast_o  (memRdLast),
    .rdData_o  (memRdData)
  );

  always #2 clk = ~clk;

  task automatic applyReset();
    rst_n = 1'b0;
    valid = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic readRecords();
    int    fd;
    string line;
    string name;
    int    mode;
    addrT  a;
    dataT  d;
    int    fill;
    recCnt = 0;
    fd = $fopen("bench/cacheInput.txt", "r");
    if (fd == 0) begin
      $display("could not open bench/cacheInput.txt");
      aborted = 1'b1;
      return;
    end
    // skip the two column description lines
    void'($fgets(line, fd));
    void'($fgets(line, fd));
    while (recCnt < MaxRecs && $fscanf(fd, "%s %d %h %h %d", name, mode, a, d, fill) == 5) begin
      recName[recCnt] = name;
      recMode[recCnt] = mode;
      recAddr[recCnt] = a;
      recData[recCnt] = d;
      recFill[recCnt] = fill;
      recCnt++;
    end
    $fclose(fd);
  endtask

  task automatic finishTest(input int idx);
    int fills;
    fills = reqCnt - reqMark[idx];
    if (rdData !== recData[idx]) begin
      $display("Mismatch in %s data: expected %h actual %h", recName[idx], recData[idx], rdData);
      testBad[idx] = 1'b1;
    end
    if (fills != recFill[idx]) begin
      $display("Mismatch in %s refills: expected %0d actual %0d", recName[idx], recFill[idx],
               fills);
      testBad[idx] = 1'b1;
    end
    // a hit answers in the cycle after acceptance
    if (recFill[idx] == 0 && cycle != acceptCyc[idx] + 1) begin
      $display("Mismatch in %s hit latency: expected 1 actual %0d", recName[idx],
               cycle - acceptCyc[idx]);
      testBad[idx] = 1'b1;
    end
    // chained behind a hit, so taken in the very next cycle
    if (idx > 0 && recMode[idx] == 1 && recFill[idx - 1] == 0
        && acceptCyc[idx] != acceptCyc[idx - 1] + 1) begin
      $display("%s was not accepted right behind the previous request", recName[idx]);
      testBad[idx] = 1'b1;
    end
    if (testBad[idx]) begin
      failCnt++;
      $display("test %s: error", recName[idx]);
    end else begin
      passCnt++;
      $display("test %s: ok", recName[idx]);
    end
  endtask

  // valid stays high until every request of the group is taken
  task automatic runGroup(input int first, input int last);
    int issueIdx;
    int respIdx;
    int acceptWait;
    int respWait;
    issueIdx   = first;
    respIdx    = first;
    acceptWait = 0;
    respWait   = 0;
    while (respIdx <= last && !aborted) begin
      valid = (issueIdx <= last);
      if (issueIdx <= last) begin
        addr = recAddr[issueIdx];
      end
      @(negedge clk);
      if (memRdReq) begin
        reqCnt++;
        if (memAddr !== (recAddr[respIdx] & ~addrT'(31))) begin
          $display("Mismatch in %s memAddr: expected %h actual %h", recName[respIdx],
                   recAddr[respIdx] & ~addrT'(31), memAddr);
          testBad[respIdx] = 1'b1;
        end
      end
      if (addrOk) begin
        acceptCyc[issueIdx] = cycle;
        reqMark[issueIdx]   = reqCnt;
        issueIdx++;
        acceptWait = 0;
      end else if (issueIdx <= last) begin
        acceptWait++;
      end
      if (dataOk) begin
        finishTest(respIdx);
        respIdx++;
        respWait = 0;
      end else if (respIdx < issueIdx) begin
        respWait++;
      end
      if (acceptWait > MaxWait) begin
        $display("timeout in %s: the request was never accepted", recName[issueIdx]);
        aborted = 1'b1;
      end
      if (respWait > MaxWait) begin
        $display("timeout in %s: no data came back from the cache", recName[respIdx]);
        aborted = 1'b1;
      end
      @(posedge clk);
      #1;
      cycle++;
    end
    valid = 1'b0;
    if (aborted) begin
      failCnt += last - respIdx + 1;
    end
  endtask

  initial begin
    int first;
    int last;
    clk     = 1'b0;
    rst_n   = 1'b0;
    valid   = 1'b0;
    addr    = '0;
    cycle   = 0;
    reqCnt  = 0;
    passCnt = 0;
    failCnt = 0;
    aborted = 1'b0;
    readRecords();
    applyReset();
    first = 0;
    while (first < recCnt && !aborted) begin
      last = first;
      while (last + 1 < recCnt && recMode[last + 1] == 1) begin
        last++;
      end
      if (recMode[first] == 2) begin
        applyReset();
      end
      runGroup(first, last);
      first = last + 1;
    end
    $display("%0d passed, %0d failed", passCnt, failCnt);
    if (failCnt == 0 && passCnt > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== bench/memModel.sv ====
module memModel (
  input  logic           clk,
  input  logic           rdReq_i,
  input  cachePkg::addrT addr_i,
  output logic           rdValid_o,
  output logic           rdLast_o,
  output cachePkg::dataT rdData_o
);
  timeunit 1ns;
  timeprecision 100ps;

  import cachePkg::*;

  int   seed;
  int   gap;
  addrT lineAddr;
  addrT wordAddr;

  initial begin
    seed      = 31;
    rdValid_o = 1'b0;
    rdLast_o  = 1'b0;
    rdData_o  = '0;
    forever begin
      // request seen mid-cycle, so the first beat comes one cycle later at the earliest
      @(negedge clk);
      if (rdReq_i) begin
        lineAddr = addr_i;
        for (int b = 0; b < BeatsPerLine; b++) begin
          gap = $unsigned($random(seed)) % 3;
          @(posedge clk);
          #1;
          rdValid_o = 1'b0;
          rdLast_o  = 1'b0;
          repeat (gap) begin
            @(posedge clk);
            #1;
          end
          // inverted address on top, address below
          wordAddr  = lineAddr + addrT'(8 * b);
          rdData_o  = {~wordAddr, wordAddr};
          rdValid_o = 1'b1;
          rdLast_o  = (b == BeatsPerLine - 1);
        end
        @(posedge clk);
        #1;
        rdValid_o = 1'b0;
        rdLast_o  = 1'b0;
      end
    end
  end

endmodule

// ==== build.f ====
verilog/cachePkg.sv
verilog/cacheCtrl.sv
verilog/refillCounter.sv
verilog/tagStore.sv
verilog/dataStore.sv
verilog/cacheTop.sv
bench/memModel.sv
bench/cacheTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the cache testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module cacheTb -f build.f -o simCache \
  && ./obj_dir/simCache > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verilog/cacheCtrl.sv ====
module cacheCtrl (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            valid_i,
  input  cachePkg::addrT  addr_i,
  input  logic            hit_i,
  input  logic            memRdLast_i,
  input  logic            memRdValid_i,
  output logic            addrOk_o,
  output logic            dataOk_o,
  output logic            lookupEn_o,
  output cachePkg::addrT  reqAddr_o,
  output logic            memRdReq_o,
  output cachePkg::addrT  memAddr_o,
  output logic            refillActive_o,
  output logic            fillWe_o,
  output logic            respondFromFill_o
);

  import cachePkg::*;

  localparam int LineBits = AddrW - TagW - IndexW;

  ctrlStateT curState;
  ctrlStateT nextState;
  logic      lookupHit;
  logic      accept;
  addrT      reqAddr;

  // a hit only counts while the lookup result is on the wires
  assign lookupHit = (curState == Lookup) && hit_i;

  // new request taken when idle or behind a hit
  assign accept = valid_i && ((curState == Idle) || lookupHit);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= Idle;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    case (curState)
      Idle: begin
        if (accept) begin
          nextState = Lookup;
        end
      end
      Lookup: begin
        if (!hit_i) begin
          nextState = MissReq;
        end else if (!valid_i) begin
          nextState = Idle;
        end
      end
      MissReq: begin
        nextState = Refill;
      end
      Refill: begin
        // stays here until the fourth beat
        if (memRdValid_i && memRdLast_i) begin
          nextState = FillDone;
        end
      end
      FillDone: begin
        nextState = Idle;
      end
      default: begin
        nextState = Idle;
      end
    endcase
  end

  // request address held for the whole lookup or refill
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

  assign addrOk_o   = accept;
  assign lookupEn_o = accept;
  assign reqAddr_o  = reqAddr;

  // response on a lookup hit or from the word caught during refill
  assign dataOk_o = lookupHit || (curState == FillDone);

  assign memRdReq_o = (curState == MissReq);
  assign memAddr_o  = {reqAddr[AddrW-1 -: TagW+IndexW], {LineBits{1'b0}}};

  // one strobe per beat accepted while refilling
  assign refillActive_o = (curState == Refill) && memRdValid_i;

  assign fillWe_o          = (curState == FillDone);
  assign respondFromFill_o = (curState == FillDone);

endmodule

// ==== verilog/cachePkg.sv ====
package cachePkg;

  // cache geometry
  localparam int AddrW        = 32;
  localparam int DataW        = 64;
  localparam int TagW         = 21;
  localparam int IndexW       = 6;
  localparam int Sets         = 64;
  localparam int Ways         = 2;
  localparam int BeatsPerLine = 4;

  // byte address split as tag | index | word | byte
  typedef logic [AddrW-1:0] addrT;

  typedef logic [DataW-1:0] dataT;

  typedef logic [TagW-1:0] tagT;

  typedef logic [IndexW-1:0] indexT;

  // word within a line and also the refill beat number
  typedef logic [$clog2(BeatsPerLine)-1:0] wordSelT;

  typedef logic [$clog2(Ways)-1:0] wayT;

  // controller states
  typedef enum logic [2:0] {
    Idle,
    Lookup,
    MissReq,
    Refill,
    FillDone
  } ctrlStateT;

endpackage

// ==== verilog/cacheTop.sv ====
module cacheTop (
  input  logic           clk,
  input  logic           rst_n,
  // load port
  input  logic           valid_i,
  input  cachePkg::addrT addr_i,
  output logic           addrOk_o,
  output logic           dataOk_o,
  output cachePkg::dataT rdData_o,
  // burst memory port
  output logic           memRdReq_o,
  output cachePkg::addrT memAddr_o,
  input  logic           memRdValid_i,
  input  logic           memRdLast_i,
  input  cachePkg::dataT memRdData_i
);

  import cachePkg::*;

  logic    lookupEn;
  addrT    reqAddr;
  logic    hit;
  wayT     hitWay;
  wayT     victimWay;
  logic    fillWe;
  logic    refillActive;
  logic    respondFromFill;
  wordSelT beatIdx;
  logic    wordMatch;

  cacheCtrl uCtrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .valid_i           (valid_i),
    .addr_i            (addr_i),
    .hit_i             (hit),
    .memRdLast_i       (memRdLast_i),
    .memRdValid_i      (memRdValid_i),
    .addrOk_o          (addrOk_o),
    .dataOk_o          (dataOk_o),
    .lookupEn_o        (lookupEn),
    .reqAddr_o         (reqAddr),
    .memRdReq_o        (memRdReq_o),
    .memAddr_o         (memAddr_o),
    .refillActive_o    (refillActive),
    .fillWe_o          (fillWe),
    .respondFromFill_o (respondFromFill)
  );

  // restarts on the memory request, steps on every beat
  refillCounter uRefillCnt (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (memRdReq_o),
    .beatValid_i (memRdValid_i),
    .reqWord_i   (reqAddr[AddrW-TagW-IndexW-1 -: $bits(wordSelT)]),
    .beatIdx_o   (beatIdx),
    .wordMatch_o (wordMatch)
  );

  // both stores read at the index of the incoming address
  tagStore uTags (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookupEn_i    (lookupEn),
    .lookupIndex_i (addr_i[AddrW-TagW-1 -: IndexW]),
    .reqAddr_i     (reqAddr),
    .fillWe_i      (fillWe),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay)
  );

  dataStore uData (
    .clk               (clk),
    .rst_n             (rst_n),
    .lookupEn_i        (lookupEn),
    .lookupIndex_i     (addr_i[AddrW-TagW-1 -: IndexW]),
    .reqAddr_i         (reqAddr),
    .hitWay_i          (hitWay),
    .victimWay_i       (victimWay),
    .beatWe_i          (refillActive),
    .beatIdx_i         (beatIdx),
    .wordMatch_i       (wordMatch),
    .beatData_i        (memRdData_i),
    .respondFromFill_i (respondFromFill),
    .rdData_o          (rdData_o)
  );

endmodule

// ==== verilog/dataStore.sv ====
module dataStore (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              lookupEn_i,
  input  cachePkg::indexT   lookupIndex_i,
  input  cachePkg::addrT    reqAddr_i,
  input  cachePkg::wayT     hitWay_i,
  input  cachePkg::wayT     victimWay_i,
  input  logic              beatWe_i,
  input  cachePkg::wordSelT beatIdx_i,
  input  logic              wordMatch_i,
  input  cachePkg::dataT    beatData_i,
  input  logic              respondFromFill_i,
  output cachePkg::dataT    rdData_o
);

  import cachePkg::*;

  dataT    rdQ [Ways][BeatsPerLine];
  dataT    fillWord;
  indexT   reqIndex;
  wordSelT reqWord;

  assign reqIndex = reqAddr_i[AddrW-TagW-1 -: IndexW];
  assign reqWord  = reqAddr_i[AddrW-TagW-IndexW-1 -: $bits(wordSelT)];

  // one ram per way and word, so a lookup reads the whole line at once
  for (genvar w = 0; w < Ways; w++) begin : gWay
    for (genvar b = 0; b < BeatsPerLine; b++) begin : gWord
      dataT mem [Sets];

      always_ff @(posedge clk) begin
        if (beatWe_i && (victimWay_i == wayT'(w)) && (beatIdx_i == wordSelT'(b))) begin
          mem[reqIndex] <= beatData_i;
        end
        if (lookupEn_i) begin
          rdQ[w][b] <= mem[lookupIndex_i];
        end
      end
    end
  end

  // requested word kept aside as it streams past
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fillWord <= '0;
    end else if (beatWe_i && wordMatch_i) begin
      fillWord <= beatData_i;
    end
  end

  assign rdData_o = respondFromFill_i ? fillWord : rdQ[hitWay_i][reqWord];

endmodule

// ==== verilog/refillCounter.sv ====
module refillCounter (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear_i,
  input  logic              beatValid_i,
  input  cachePkg::wordSelT reqWord_i,
  output cachePkg::wordSelT beatIdx_o,
  output logic              wordMatch_o
);

  import cachePkg::*;

  wordSelT beatCnt;

  // beats come in ascending word order, so the count is the word index
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (clear_i) begin
      beatCnt <= '0;
    end else if (beatValid_i) begin
      // wraps back to zero after the last beat
      beatCnt <= beatCnt + wordSelT'(1);
    end
  end

  assign beatIdx_o = beatCnt;

  // the beat carrying the word that was asked for
  assign wordMatch_o = beatValid_i && (beatCnt == reqWord_i);

endmodule

// ==== verilog/tagStore.sv ====
module tagStore (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            lookupEn_i,
  input  cachePkg::indexT lookupIndex_i,
  input  cachePkg::addrT  reqAddr_i,
  input  logic            fillWe_i,
  output logic            hit_o,
  output cachePkg::wayT   hitWay_o,
  output cachePkg::wayT   victimWay_o
);

  import cachePkg::*;

  tagT             tagArr [Ways][Sets];
  logic [Sets-1:0] validBits [Ways];
  // least recently used way of each set
  logic [Sets-1:0] lruBits;

  tagT             tagQ [Ways];
  logic [Ways-1:0] validQ;
  logic [Ways-1:0] hitVec;
  logic            lookupPending;
  tagT             reqTag;
  indexT           reqIndex;

  assign reqTag   = reqAddr_i[AddrW-1 -: TagW];
  assign reqIndex = reqAddr_i[AddrW-TagW-1 -: IndexW];

  // tag rams written once per refill
  always_ff @(posedge clk) begin
    if (fillWe_i) begin
      tagArr[victimWay_o][reqIndex] <= reqTag;
    end
  end

  // synchronous read of the set being looked up
  always_ff @(posedge clk) begin
    if (lookupEn_i) begin
      for (int w = 0; w < Ways; w++) begin
        tagQ[w]   <= tagArr[w][lookupIndex_i];
        validQ[w] <= validBits[w][lookupIndex_i];
      end
    end
  end

  // marks the cycle in which the compare result is meaningful
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lookupPending <= 1'b0;
    end else begin
      lookupPending <= lookupEn_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '{default: '0};
    end else if (fillWe_i) begin
      validBits[victimWay_o][reqIndex] <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lruBits <= '0;
    end else if (fillWe_i) begin
      lruBits[reqIndex] <= ~victimWay_o;
    end else if (hit_o) begin
      // the way just used becomes most recent
      lruBits[reqIndex] <= ~hitWay_o;
    end
  end

  always_comb begin
    for (int w = 0; w < Ways; w++) begin
      hitVec[w] = validQ[w] && (tagQ[w] == reqTag);
    end
  end

  assign hit_o    = lookupPending && (|hitVec);
  assign hitWay_o = wayT'(hitVec[1]);

  // empty way first, otherwise the older one
  always_comb begin
    if (!validBits[0][reqIndex]) begin
      victimWay_o = wayT'(0);
    end else if (!validBits[1][reqIndex]) begin
      victimWay_o = wayT'(1);
    end else begin
      victimWay_o = wayT'(lruBits[reqIndex]);
    end
  end

endmodule
